//--- Makefile
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module cpu_tb -Mdir obj_dir

run: compile
	./obj_dir/Vcpu_tb > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- sources.f
+incdir+src
src/cpu_pkg.sv
src/ctrl_if.sv
src/control_unit.sv
src/register_file.sv
src/alu.sv
src/branch_unit.sv
src/cpu_core.sv
tb/clk_gen.sv
tb/cpu_props.sv
tb/cpu_tb.sv

//--- src/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module alu import cpu_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  alu_op_t alu_op,
  input  word_t   a,
  input  word_t   b,
  output word_t   result,
  output flags_t  flags
);

  localparam int MSB = `DATA_BITS - 1;

  word_t                         sum;
  word_t                         diff;
  logic                          add_ovf;
  logic                          sub_ovf;
  logic                          ovf;
  logic [$clog2(`DATA_BITS)-1:0] shamt;

  assign sum   = a + b;
  assign diff  = a - b;
  assign shamt = b[$clog2(`DATA_BITS)-1:0]; // low bits only.

  // signed overflow.
  assign add_ovf = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
  assign sub_ovf = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);

  always_comb begin
    ovf = 1'b0;
    case (alu_op)
      `ALU_OP_ADD: begin
        result = sum;
        ovf    = add_ovf;
      end
      `ALU_OP_SUB,
      `ALU_OP_CMP: begin
        result = diff;
        ovf    = sub_ovf;
      end
      `ALU_OP_NOT:  result = ~a;
      `ALU_OP_AND,
      `ALU_OP_TEST: result = a & b;
      `ALU_OP_OR:   result = a | b;
      `ALU_OP_NAND: result = ~(a & b);
      `ALU_OP_NOR:  result = ~(a | b);
      `ALU_OP_XOR:  result = a ^ b;
      `ALU_OP_MOV:  result = a;
      `ALU_OP_MOVI: result = b;
      `ALU_OP_SAR:  result = word_t'($signed(a) >>> shamt);
      `ALU_OP_SHR:  result = a >> shamt;
      `ALU_OP_SHL:  result = a << shamt;
      default:      result = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags <= '0;
    end else if (alu_op != `ALU_OP_NOP) begin // nop holds the last compare.
      flags.zero     <= (result == '0);
      flags.sign     <= result[MSB];
      flags.overflow <= ovf;
    end
  end

endmodule

`default_nettype wire

//--- src/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module branch_unit import cpu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  jump_op_t jop,
  input  flags_t   flags,
  input  pc_t      target,
  input  word_t    reg_target,
  output pc_t      pc
);

  logic lt;
  logic le;
  logic taken;

  assign lt = flags.sign ^ flags.overflow; // signed less than.
  assign le = lt | flags.zero;

  always_comb begin
    case (jop)
      `JMP_OP_J,
      `JMP_OP_JR:  taken = 1'b1;
      `JMP_OP_JEQ,
      `JMP_OP_JZ:  taken = flags.zero;
      `JMP_OP_JNE,
      `JMP_OP_JNZ: taken = !flags.zero;
      `JMP_OP_JL:  taken = lt;
      `JMP_OP_JLE: taken = le;
      `JMP_OP_JG:  taken = !le;
      `JMP_OP_JGE: taken = !lt;
      `JMP_OP_JO:  taken = flags.overflow;
      default:     taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (!taken) begin
      pc <= pc + 1'b1;
    end else if (jop == `JMP_OP_JR) begin
      pc <= pc_t'(reg_target); // register indirect.
    end else begin
      pc <= target;
    end
  end

endmodule

`default_nettype wire

//--- src/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module control_unit import cpu_pkg::*; (
  input  logic    clk, // decode is purely combinational.
  input  opcode_t opcode,
  ctrl_if.decoder ctrl
);

  alu_op_t grp_alu_op;

  // both alu groups share the low four opcode bits.
  always_comb begin
    case ({2'b00, opcode[3:0]})
      `OP_CODE_ADD:  grp_alu_op = `ALU_OP_ADD;
      `OP_CODE_SUB:  grp_alu_op = `ALU_OP_SUB;
      `OP_CODE_NOT:  grp_alu_op = `ALU_OP_NOT;
      `OP_CODE_AND:  grp_alu_op = `ALU_OP_AND;
      `OP_CODE_OR:   grp_alu_op = `ALU_OP_OR;
      `OP_CODE_NAND: grp_alu_op = `ALU_OP_NAND;
      `OP_CODE_NOR:  grp_alu_op = `ALU_OP_NOR;
      `OP_CODE_MOV:  grp_alu_op = `ALU_OP_MOV;
      `OP_CODE_SAR:  grp_alu_op = `ALU_OP_SAR;
      `OP_CODE_SHR:  grp_alu_op = `ALU_OP_SHR;
      `OP_CODE_SHL:  grp_alu_op = `ALU_OP_SHL;
      `OP_CODE_XOR:  grp_alu_op = `ALU_OP_XOR;
      `OP_CODE_TEST: grp_alu_op = `ALU_OP_TEST;
      `OP_CODE_CMP:  grp_alu_op = `ALU_OP_CMP;
      default:       grp_alu_op = `ALU_OP_NOP;
    endcase
  end

  always_comb begin
    ctrl.reg_dst     = 1'b0;
    ctrl.mem_to_reg  = 1'b0;
    ctrl.alu_op      = `ALU_OP_NOP; // keeps the flags.
    ctrl.alu_src     = 1'b0;
    ctrl.reg_write   = 1'b0;
    ctrl.mem_op      = `MEM_OP_NOP;
    ctrl.address_src = 1'b0;
    ctrl.jop         = `JMP_OP_NOP;

    case (opcode[5:4])
      `OP_GRP_REG: begin
        ctrl.reg_dst   = 1'b1;
        ctrl.alu_op    = grp_alu_op;
        ctrl.reg_write = (grp_alu_op != `ALU_OP_NOP);
      end
      `OP_GRP_IMM: begin
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = (opcode == `OP_CODE_MOVI) ? `ALU_OP_MOVI : grp_alu_op;
        ctrl.reg_write = (grp_alu_op != `ALU_OP_NOP);
      end
      `OP_GRP_MEM: begin
        ctrl.mem_to_reg = 1'b1; // loads land in rt.
        case (opcode)
          `OP_CODE_LW: begin
            ctrl.mem_op    = `MEM_OP_READ;
            ctrl.reg_write = 1'b1;
          end
          `OP_CODE_LA: begin
            ctrl.mem_op      = `MEM_OP_READ;
            ctrl.reg_write   = 1'b1;
            ctrl.address_src = 1'b1;
          end
          `OP_CODE_SW: ctrl.mem_op = `MEM_OP_WRITE;
          `OP_CODE_SA: begin
            ctrl.mem_op      = `MEM_OP_WRITE;
            ctrl.address_src = 1'b1;
          end
          default: ctrl.mem_op = `MEM_OP_NOP;
        endcase
      end
      default: begin
        case (opcode)
          `OP_CODE_JMP: ctrl.jop = `JMP_OP_J;
          `OP_CODE_JE:  ctrl.jop = `JMP_OP_JEQ;
          `OP_CODE_JNE: ctrl.jop = `JMP_OP_JNE;
          `OP_CODE_JL:  ctrl.jop = `JMP_OP_JL;
          `OP_CODE_JLE: ctrl.jop = `JMP_OP_JLE;
          `OP_CODE_JG:  ctrl.jop = `JMP_OP_JG;
          `OP_CODE_JGE: ctrl.jop = `JMP_OP_JGE;
          `OP_CODE_JZ:  ctrl.jop = `JMP_OP_JZ;
          `OP_CODE_JNZ: ctrl.jop = `JMP_OP_JNZ;
          `OP_CODE_JO:  ctrl.jop = `JMP_OP_JO;
          `OP_CODE_JR:  ctrl.jop = `JMP_OP_JR;
          default:      ctrl.jop = `JMP_OP_NOP;
        endcase
      end
    endcase
  end

endmodule

`default_nettype wire

//--- src/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core import cpu_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  instr_t instr,
  input  word_t  mem_rdata,
  output pc_t    pc,
  output word_t  mem_addr,
  output word_t  mem_wdata,
  output logic   mem_read,
  output logic   mem_write
);

  opcode_t  opcode;
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t rd;
  word_t    imm;
  word_t    rs_data;
  word_t    rt_data;
  word_t    alu_b;
  word_t    alu_result;
  word_t    wr_data;
  reg_idx_t wr_addr;
  flags_t   flags;

  ctrl_if ctrl ();

  assign opcode = instr[31:26];
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11]; // overlaps the top of imm.
  assign imm    = instr[15:0];

  // datapath muxes.
  assign wr_addr = ctrl.reg_dst ? rd : rt;
  assign alu_b   = ctrl.alu_src ? imm : rt_data;
  assign wr_data = ctrl.mem_to_reg ? mem_rdata : alu_result;

  assign mem_addr  = ctrl.address_src ? imm : rs_data;
  assign mem_wdata = rt_data;
  assign mem_read  = ctrl.mem_read;
  assign mem_write = ctrl.mem_write;

  control_unit u_control (
    .clk    (clk),
    .opcode (opcode),
    .ctrl   (ctrl)
  );

  register_file u_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs_addr (rs),
    .rt_addr (rt),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .wr_en   (ctrl.reg_write),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  alu u_alu (
    .clk    (clk),
    .rst_n  (rst_n),
    .alu_op (ctrl.alu_op),
    .a      (rs_data),
    .b      (alu_b),
    .result (alu_result),
    .flags  (flags)
  );

  branch_unit u_branch (
    .clk        (clk),
    .rst_n      (rst_n),
    .jop        (ctrl.jop),
    .flags      (flags),
    .target     (pc_t'(imm)),
    .reg_target (rs_data),
    .pc         (pc)
  );

endmodule

`default_nettype wire

//--- src/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define OP_CODE_BITS  6
`define REG_ADDR_BITS 5
`define DATA_BITS     16
`define INSTR_BITS    32
`define PC_BITS       16
`define ALU_OP_BITS   4
`define MEM_OP_BITS   2
`define JUMP_BITS     4

// alu operations.
`define ALU_OP_NOP  4'd0
`define ALU_OP_ADD  4'd1
`define ALU_OP_SUB  4'd2
`define ALU_OP_NOT  4'd3
`define ALU_OP_AND  4'd4
`define ALU_OP_OR   4'd5
`define ALU_OP_NAND 4'd6
`define ALU_OP_NOR  4'd7
`define ALU_OP_MOV  4'd8
`define ALU_OP_MOVI 4'd9
`define ALU_OP_SAR  4'd10
`define ALU_OP_SHR  4'd11
`define ALU_OP_SHL  4'd12
`define ALU_OP_XOR  4'd13
`define ALU_OP_TEST 4'd14
`define ALU_OP_CMP  4'd15

`define MEM_OP_NOP   2'd0
`define MEM_OP_READ  2'd1
`define MEM_OP_WRITE 2'd2

`define JMP_OP_NOP 4'd0
`define JMP_OP_J   4'd1
`define JMP_OP_JEQ 4'd2
`define JMP_OP_JNE 4'd3
`define JMP_OP_JL  4'd4
`define JMP_OP_JLE 4'd5
`define JMP_OP_JG  4'd6
`define JMP_OP_JGE 4'd7
`define JMP_OP_JZ  4'd8
`define JMP_OP_JNZ 4'd9
`define JMP_OP_JO  4'd10
`define JMP_OP_JR  4'd11

// top two opcode bits.
`define OP_GRP_REG 2'b00
`define OP_GRP_IMM 2'b01
`define OP_GRP_MEM 2'b10
`define OP_GRP_JMP 2'b11

// register forms. immediate forms sit 6'h10 above these.
`define OP_CODE_ADD  6'h00
`define OP_CODE_SUB  6'h01
`define OP_CODE_NOT  6'h02
`define OP_CODE_AND  6'h03
`define OP_CODE_OR   6'h04
`define OP_CODE_NAND 6'h05
`define OP_CODE_NOR  6'h06
`define OP_CODE_MOV  6'h07
`define OP_CODE_SAR  6'h08
`define OP_CODE_SHR  6'h09
`define OP_CODE_SHL  6'h0A
`define OP_CODE_XOR  6'h0B
`define OP_CODE_TEST 6'h0C
`define OP_CODE_CMP  6'h0D
`define OP_CODE_MOVI 6'h17

`define OP_CODE_LW 6'h20
`define OP_CODE_SW 6'h21
`define OP_CODE_LA 6'h22
`define OP_CODE_SA 6'h23

`define OP_CODE_JMP 6'h30
`define OP_CODE_JE  6'h31
`define OP_CODE_JNE 6'h32
`define OP_CODE_JL  6'h33
`define OP_CODE_JLE 6'h34
`define OP_CODE_JG  6'h35
`define OP_CODE_JGE 6'h36
`define OP_CODE_JZ  6'h37
`define OP_CODE_JNZ 6'h38
`define OP_CODE_JO  6'h39
`define OP_CODE_JR  6'h3A

`endif

//--- src/cpu_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package cpu_pkg;

  typedef logic [`DATA_BITS-1:0]     word_t;
  typedef logic [`INSTR_BITS-1:0]    instr_t;
  typedef logic [`OP_CODE_BITS-1:0]  opcode_t;
  typedef logic [`REG_ADDR_BITS-1:0] reg_idx_t;
  typedef logic [`PC_BITS-1:0]       pc_t;

  typedef logic [`ALU_OP_BITS-1:0] alu_op_t;
  typedef logic [`MEM_OP_BITS-1:0] mem_op_t;
  typedef logic [`JUMP_BITS-1:0]   jump_op_t;

  // flags kept by the alu for conditional jumps.
  typedef struct packed {
    logic zero;
    logic sign;
    logic overflow;
  } flags_t;

endpackage

`default_nettype wire

//--- src/ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

interface ctrl_if import cpu_pkg::*; ();
  logic     reg_dst;     // write rd instead of rt.
  logic     mem_to_reg;
  alu_op_t  alu_op;
  logic     alu_src;     // operand b from the immediate.
  logic     reg_write;
  mem_op_t  mem_op;
  logic     address_src; // address from the immediate.
  jump_op_t jop;
  logic     mem_read;
  logic     mem_write;

  // level strobes for the memory ports.
  assign mem_read  = (mem_op == `MEM_OP_READ);
  assign mem_write = (mem_op == `MEM_OP_WRITE);

  modport decoder (
    output reg_dst, mem_to_reg, alu_op, alu_src, reg_write, mem_op, address_src, jop
  );

  modport datapath (
    input reg_dst, mem_to_reg, alu_op, alu_src, reg_write, mem_op, address_src, jop,
    input mem_read, mem_write
  );
endinterface

`default_nettype wire

//--- src/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file import cpu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  reg_idx_t rs_addr,
  input  reg_idx_t rt_addr,
  output word_t    rs_data,
  output word_t    rt_data,
  input  logic     wr_en,
  input  reg_idx_t wr_addr,
  input  word_t    wr_data
);

  localparam int NUM_REGS = 2 ** $bits(reg_idx_t);

  word_t regs [NUM_REGS];

  // reads are combinational.
  assign rs_data = regs[rs_addr];
  assign rt_data = regs[rt_addr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data; // r0 is writable too.
    end
  end

endmodule

`default_nettype wire

//--- tb/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
  output logic clk
);

  localparam int HALF_PERIOD = 10; // 20 ns clock.

  initial begin
    clk = 1'b0;
  end

  always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

//--- tb/cpu_props.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_props import cpu_pkg::*; (
  input logic   clk,
  input logic   rst_n,
  input instr_t instr,
  input pc_t    pc,
  input logic   mem_read,
  input logic   mem_write
);

  logic is_jump;
  int   fail_count; // failed assertions so far.

  assign is_jump = (instr[31:30] == 2'b11); // jump group.

  strobes_exclusive: assert property (@(posedge clk) !(mem_read && mem_write))
    else begin
      $error("mem_read and mem_write high in the same cycle");
      fail_count++;
    end

  // the reset edge leaves pc at zero.
  pc_zero_in_reset: assert property (@(posedge clk) !rst_n |=> (pc == '0))
    else begin
      $error("pc not zero after a reset cycle");
      fail_count++;
    end

  pc_steps_by_one: assert property (
    @(posedge clk) (rst_n && !is_jump) |=> (pc == $past(pc) + 16'd1))
    else begin
      $error("pc did not step by one after a non-jump instruction");
      fail_count++;
    end

endmodule

`default_nettype wire

//--- tb/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu_tb import cpu_pkg::*; ();

  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 10;
  localparam int WD_MARGIN  = 20;

  typedef struct {
    instr_t instr;
    word_t  rdata;     // value the data memory returns.
    pc_t    exp_pc;    // pc after the edge.
    logic   exp_read;
    logic   exp_write;
    word_t  exp_addr;
    word_t  exp_wdata;
  } entry_t;

  logic   clk;
  logic   rst_n;
  instr_t instr;
  word_t  mem_rdata;
  pc_t    pc;
  word_t  mem_addr;
  word_t  mem_wdata;
  logic   mem_read;
  logic   mem_write;

  entry_t      tbl[$];
  int          entry_errs[];
  int          errors;
  int          checks;
  int          asrt_fails;
  bit          tbl_ready;
  logic [31:0] rng;

  // reference model state.
  word_t  model_regs [32];
  flags_t model_flags;
  pc_t    model_pc;

  clk_gen u_clk (.clk(clk));

  cpu_core UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .instr     (instr),
    .mem_rdata (mem_rdata),
    .pc        (pc),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_read  (mem_read),
    .mem_write (mem_write)
  );

  bind cpu_core cpu_props u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .instr     (instr),
    .pc        (pc),
    .mem_read  (mem_read),
    .mem_write (mem_write)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t rand_word();
    rng = xorshift32(rng);
    return rng[15:0];
  endfunction

  function automatic instr_t r_form(opcode_t op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
    return {op, rs, rt, rd, 11'h000};
  endfunction

  function automatic instr_t i_form(opcode_t op, reg_idx_t rt, reg_idx_t rs, word_t imm);
    return {op, rs, rt, imm};
  endfunction

  // result of one alu operation selected by the low opcode nibble.
  function automatic word_t model_alu(input logic [3:0] sub, input logic imm_form,
                                      input word_t a, input word_t b, output logic ovf);
    logic [16:0] wide;
    word_t       res;
    ovf = 1'b0;
    case (sub)
      4'h0: begin
        wide = {a[15], a} + {b[15], b};
        res  = wide[15:0];
        ovf  = wide[16] ^ wide[15]; // sign extended sum leaves range.
      end
      4'h1, 4'hD: begin
        wide = {a[15], a} - {b[15], b};
        res  = wide[15:0];
        ovf  = wide[16] ^ wide[15];
      end
      4'h2:       res = ~a;
      4'h3, 4'hC: res = a & b;
      4'h4:       res = a | b;
      4'h5:       res = ~(a & b);
      4'h6:       res = ~(a | b);
      4'h7:       res = imm_form ? b : a; // mov or movi.
      4'h8:       res = (a >> b[3:0]) | (a[15] ? ~(16'hFFFF >> b[3:0]) : 16'h0000);
      4'h9:       res = a >> b[3:0];
      4'hA:       res = a << b[3:0];
      4'hB:       res = a ^ b;
      default:    res = '0;
    endcase
    return res;
  endfunction

  function automatic logic model_taken(opcode_t op);
    logic lt;
    lt = model_flags.sign != model_flags.overflow;
    case (op)
      `OP_CODE_JMP, `OP_CODE_JR: return 1'b1;
      `OP_CODE_JE,  `OP_CODE_JZ: return model_flags.zero;
      `OP_CODE_JNE, `OP_CODE_JNZ: return !model_flags.zero;
      `OP_CODE_JL:  return lt;
      `OP_CODE_JLE: return lt || model_flags.zero;
      `OP_CODE_JG:  return !(lt || model_flags.zero);
      `OP_CODE_JGE: return !lt;
      `OP_CODE_JO:  return model_flags.overflow;
      default:      return 1'b0;
    endcase
  endfunction

  // runs the model on one instruction and queues the expected values.
  task automatic add_entry(input instr_t ins, input word_t rdata);
    entry_t   e;
    opcode_t  op;
    reg_idx_t rs;
    reg_idx_t rt;
    word_t    b;
    word_t    res;
    logic     ovf;
    logic     taken;
    op = ins[31:26];
    rs = ins[25:21];
    rt = ins[20:16];
    e.instr     = ins;
    e.rdata     = rdata;
    e.exp_read  = 1'b0;
    e.exp_write = 1'b0;
    e.exp_addr  = model_regs[rs];
    e.exp_wdata = model_regs[rt];
    taken       = 1'b0;
    case (op[5:4])
      2'b00, 2'b01: begin
        b   = op[4] ? ins[15:0] : model_regs[rt];
        res = model_alu(op[3:0], op[4], model_regs[rs], b, ovf);
        model_flags.zero     = (res == 16'h0000);
        model_flags.sign     = res[15];
        model_flags.overflow = ovf;
        if (op[4]) model_regs[rt] = res;
        else model_regs[ins[15:11]] = res;
      end
      2'b10: begin
        if (op == `OP_CODE_LA || op == `OP_CODE_SA) e.exp_addr = ins[15:0];
        if (op == `OP_CODE_LW || op == `OP_CODE_LA) begin
          e.exp_read     = 1'b1;
          model_regs[rt] = rdata;
        end else begin
          e.exp_write = 1'b1;
        end
      end
      default: taken = model_taken(op);
    endcase
    if (!taken) model_pc = model_pc + 16'd1;
    else if (op == `OP_CODE_JR) model_pc = model_regs[rs];
    else model_pc = ins[15:0];
    e.exp_pc = model_pc;
    tbl.push_back(e);
  endtask

  task automatic build_program();
    word_t    v;
    word_t    d;
    reg_idx_t lhs [4];
    reg_idx_t rhs [4];
    for (int k = 0; k < 32; k++) model_regs[k] = '0;
    model_flags = '0;
    model_pc    = '0;
    // loads into r1 to r8.
    for (int k = 1; k <= 8; k++) begin
      v = rand_word();
      d = rand_word();
      if (k % 2 == 1) add_entry(i_form(`OP_CODE_LW, reg_idx_t'(k), reg_idx_t'(k - 1), v), d);
      else add_entry(i_form(`OP_CODE_LA, reg_idx_t'(k), 5'd0, v), d);
    end
    for (int k = 0; k < 14; k++) begin
      add_entry(r_form(opcode_t'(k), 5'd10, reg_idx_t'(1 + k % 8), reg_idx_t'(8 - k % 8)), '0);
      add_entry(i_form(`OP_CODE_SW, 5'd10, reg_idx_t'(2 + k % 4), '0), '0);
    end
    for (int k = 0; k < 14; k++) begin
      v = rand_word();
      add_entry(i_form(opcode_t'(16 + k), 5'd11, reg_idx_t'(1 + k % 8), v), '0);
      v = rand_word();
      add_entry(i_form(`OP_CODE_SA, 5'd11, 5'd0, v), '0);
    end
    add_entry(i_form(`OP_CODE_MOVI, 5'd20, 5'd0, 16'h0005), '0);
    add_entry(i_form(`OP_CODE_MOVI, 5'd21, 5'd0, 16'h0009), '0);
    add_entry(i_form(`OP_CODE_MOVI, 5'd22, 5'd0, 16'h8000), '0);
    add_entry(i_form(`OP_CODE_MOVI, 5'd23, 5'd0, 16'h0001), '0);
    lhs = '{5'd20, 5'd20, 5'd21, 5'd22}; // equal, smaller, larger, overflow.
    rhs = '{5'd20, 5'd21, 5'd20, 5'd23};
    for (int p = 0; p < 4; p++) begin
      add_entry(r_form(`OP_CODE_CMP, 5'd31, lhs[p], rhs[p]), '0);
      for (int j = 1; j <= 9; j++) begin
        add_entry(i_form(opcode_t'(48 + j), 5'd0, 5'd0, rand_word()), '0);
      end
    end
    // memory ops between the compare and the jump.
    add_entry(r_form(`OP_CODE_CMP, 5'd31, 5'd20, 5'd20), '0);
    add_entry(i_form(`OP_CODE_SW, 5'd20, 5'd1, '0), '0);
    add_entry(i_form(`OP_CODE_JE, 5'd0, 5'd0, 16'h0040), '0);
    add_entry(r_form(`OP_CODE_CMP, 5'd31, 5'd21, 5'd21), '0);
    add_entry(i_form(`OP_CODE_LW, 5'd30, 5'd21, '0), rand_word());
    add_entry(i_form(`OP_CODE_SA, 5'd30, 5'd0, 16'h0123), '0);
    add_entry(i_form(`OP_CODE_JE, 5'd0, 5'd0, 16'h0080), '0);
    add_entry(i_form(`OP_CODE_JMP, 5'd0, 5'd0, rand_word()), '0);
    add_entry(i_form(`OP_CODE_JR, 5'd0, 5'd1, '0), '0);
    add_entry(i_form(`OP_CODE_JR, 5'd0, 5'd4, '0), '0);
  endtask

  task automatic count_error(input int idx);
    errors++;
    entry_errs[idx]++;
  endtask

  task automatic check_word(input int idx, input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED entry %0d %s: got %h, expected %h", idx, name, got, exp);
      count_error(idx);
    end
  endtask

  task automatic check_pc(input int idx, input string name, input pc_t got, input pc_t exp);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED entry %0d %s: got %h, expected %h", idx, name, got, exp);
      count_error(idx);
    end
  endtask

  task automatic check_strobe(input int idx, input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED entry %0d %s: got %h, expected %h", idx, name, got, exp);
      count_error(idx);
    end
  endtask

  task automatic report_entry(input int idx);
    $display("entry %0d instr %h pc %h: %s", idx, tbl[idx].instr, tbl[idx].exp_pc,
             (entry_errs[idx] == 0) ? "ok" : "mismatch");
  endtask

  initial begin
    rst_n     = 1'b0;
    instr     = '0;  // add keeps both strobes low.
    mem_rdata = '0;
    errors    = 0;
    checks    = 0;
    rng       = 32'h6243a9e2;
    build_program();
    entry_errs = new[tbl.size()];
    tbl_ready  = 1'b1;
    repeat (RST_CYCLES - 1) @(posedge clk);
    for (int i = 0; i < tbl.size(); i++) begin
      @(posedge clk);
      if (i == 0) rst_n <= 1'b1; // released on the tenth edge.
      instr     <= tbl[i].instr;
      mem_rdata <= tbl[i].rdata;
      @(negedge clk);
      if (i == 0) begin
        check_pc(0, "pc", pc, 16'h0000);
      end else begin
        check_pc(i - 1, "pc", pc, tbl[i - 1].exp_pc);
        report_entry(i - 1);
      end
      check_strobe(i, "mem_read", mem_read, tbl[i].exp_read);
      check_strobe(i, "mem_write", mem_write, tbl[i].exp_write);
      if (tbl[i].exp_read || tbl[i].exp_write) begin
        check_word(i, "mem_addr", mem_addr, tbl[i].exp_addr);
      end
      if (tbl[i].exp_write) check_word(i, "mem_wdata", mem_wdata, tbl[i].exp_wdata);
    end
    @(posedge clk);
    @(negedge clk);
    check_pc(tbl.size() - 1, "pc", pc, tbl[tbl.size() - 1].exp_pc);
    report_entry(tbl.size() - 1);
    asrt_fails = UUT.u_props.fail_count;
    $display("done: %0d entries, %0d checks, %0d errors, %0d assertion failures",
             tbl.size(), checks, errors, asrt_fails);
    if (errors == 0 && asrt_fails == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // watchdog sized from the table.
  initial begin
    wait (tbl_ready);
    #((tbl.size() + RST_CYCLES + WD_MARGIN) * CLK_PERIOD);
    $display("watchdog: the run did not finish in the expected time");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
